// File: hdl/fpga_fabric_pkg.sv
package fpga_fabric_pkg;

  // Inputs per LUT, fixed by the architecture
  localparam int LUT_K = 4;

  // Entries in one truth table
  localparam int LUT_SIZE = 2 ** LUT_K;

  // Bits per outgoing track source field
  localparam int TRACK_SRC_W = 2;

  // Bit n is the LUT output when the inputs, input 0 as LSB, read as n
  typedef logic [LUT_SIZE-1:0] lut_table_t;

  // What drives one outgoing track of a switch box
  typedef enum logic [TRACK_SRC_W-1:0] {
    TRACK_PASS = 2'd0,  // same-numbered west track
    TRACK_COMB = 2'd1,  // LUT (track mod NUM_LUTS), combinational
    TRACK_SYNC = 2'd2,  // LUT (track mod NUM_LUTS), registered
    TRACK_OFF  = 2'd3   // constant zero
  } track_src_e;

  // Tile configuration chain layout, from bit 0 upward
  //   comb section
  //     NUM_LUTS truth tables of LUT_SIZE bits, LUT 0 lowest
  //     NUM_LUTS*LUT_K input selects of log2(CHAN_W) bits, LUT-major
  //     CHAN_W track sources of TRACK_SRC_W bits, track 0 lowest
  //   mem section
  //     NUM_LUTS register initial values, LUT 0 lowest
  // Chain length is comb bits plus mem bits
  // With the default sizes: 2*16 + 8*2 + 4*2 + 2 = 58

endpackage

// File: hdl/tile_config_if.sv
interface tile_config_if #(
  parameter int NUM_LUTS = 2,
  parameter int CHAN_W   = 4
);

  localparam int SEL_W = $clog2(CHAN_W);

  // Decoded configuration of one tile
  fpga_fabric_pkg::lut_table_t [NUM_LUTS-1:0] lut_tables;
  logic [NUM_LUTS*fpga_fabric_pkg::LUT_K-1:0][SEL_W-1:0] lut_in_sel;
  fpga_fabric_pkg::track_src_e [CHAN_W-1:0] track_src;
  logic [NUM_LUTS-1:0] reg_init;

  // Register load strobe, follows set_hard
  logic cen;

  modport source (
    output lut_tables, lut_in_sel, track_src, reg_init, cen
  );

  modport slice (
    input lut_tables, reg_init, cen
  );

  modport cb (
    input lut_in_sel
  );

  modport sb (
    input track_src
  );

endinterface

// File: hdl/config_tile.sv
module config_tile #(
  parameter int NUM_LUTS = 2,
  parameter int CHAN_W   = 4
) (
  input  logic cclk,
  input  logic reset,
  input  logic shift_enable,
  input  logic set_hard,
  input  logic shift_in,
  output logic shift_out,
  tile_config_if.source cfg
);

  localparam int SEL_W    = $clog2(CHAN_W);
  localparam int LUT_BITS = NUM_LUTS * fpga_fabric_pkg::LUT_SIZE;
  localparam int SEL_BITS = NUM_LUTS * fpga_fabric_pkg::LUT_K * SEL_W;
  localparam int SRC_BITS = CHAN_W * fpga_fabric_pkg::TRACK_SRC_W;
  localparam int COMB_N   = LUT_BITS + SEL_BITS + SRC_BITS;
  localparam int MEM_N    = NUM_LUTS;
  localparam int CHAIN_N  = COMB_N + MEM_N;

  // Field offsets inside the comb section
  localparam int SEL_LO = LUT_BITS;
  localparam int SRC_LO = LUT_BITS + SEL_BITS;

  logic [CHAIN_N-1:0] chain;
  logic [COMB_N-1:0]  shadow;

  // New bits enter at the top and walk toward bit 0
  always_ff @(posedge cclk) begin
    if (reset) begin
      chain <= '0;
    end else if (shift_enable) begin
      chain <= {shift_in, chain[CHAIN_N-1:1]};
    end
  end

  // Comb section takes effect only on set_hard
  always_ff @(posedge cclk) begin
    if (reset) begin
      shadow <= '0;
    end else if (set_hard) begin
      shadow <= chain[COMB_N-1:0];
    end
  end

  assign shift_out = chain[0];

  assign cfg.lut_tables = shadow[LUT_BITS-1:0];
  assign cfg.lut_in_sel = shadow[SEL_LO +: SEL_BITS];

  for (genvar t = 0; t < CHAN_W; t++) begin : g_track_src
    assign cfg.track_src[t] = fpga_fabric_pkg::track_src_e'(
      shadow[SRC_LO + t*fpga_fabric_pkg::TRACK_SRC_W +: fpga_fabric_pkg::TRACK_SRC_W]);
  end

  // Register init values come straight from the chain
  assign cfg.reg_init = chain[COMB_N +: MEM_N];
  assign cfg.cen      = set_hard;

endmodule

// File: hdl/slicel.sv
module slicel #(
  parameter int NUM_LUTS = 2
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [NUM_LUTS*fpga_fabric_pkg::LUT_K-1:0] lut_in,
  output logic [NUM_LUTS-1:0]                     comb_out,
  output logic [NUM_LUTS-1:0]                     sync_out,
  tile_config_if.slice                            cfg
);

  localparam int LUT_K = fpga_fabric_pkg::LUT_K;

  // Per-LUT evaluation
  for (genvar l = 0; l < NUM_LUTS; l++) begin : g_lut
    logic [LUT_K-1:0]            addr;
    fpga_fabric_pkg::lut_table_t lut_table;

    // Input 0 is the address LSB
    assign addr      = lut_in[l*LUT_K +: LUT_K];
    assign lut_table = cfg.lut_tables[l];

    assign comb_out[l] = lut_table[addr];
  end

  // One register per LUT
  // cen loads the configured initial value, else capture the LUT output
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_out <= '0;
    end else if (cfg.cen) begin
      sync_out <= cfg.reg_init;
    end else begin
      sync_out <= comb_out;
    end
  end

endmodule

// File: hdl/connection_block.sv
module connection_block #(
  parameter int NUM_LUTS = 2,
  parameter int CHAN_W   = 4
) (
  input  logic [CHAN_W-1:0]                           west_chan,
  output logic [NUM_LUTS*fpga_fabric_pkg::LUT_K-1:0] lut_in,
  tile_config_if.cb                                   cfg
);

  localparam int NUM_INS = NUM_LUTS * fpga_fabric_pkg::LUT_K;
  localparam int SEL_W   = $clog2(CHAN_W);

  // Each LUT input picks one west track
  // Select index i covers LUT i/LUT_K, input i%LUT_K
  for (genvar i = 0; i < NUM_INS; i++) begin : g_lut_in
    logic [SEL_W-1:0] sel;

    assign sel       = cfg.lut_in_sel[i];
    assign lut_in[i] = west_chan[sel];
  end

endmodule

// File: hdl/switch_box.sv
module switch_box #(
  parameter int NUM_LUTS = 2,
  parameter int CHAN_W   = 4
) (
  input  logic [CHAN_W-1:0]   west_chan,
  input  logic [NUM_LUTS-1:0] comb_out,
  input  logic [NUM_LUTS-1:0] sync_out,
  output logic [CHAN_W-1:0]   east_chan,
  tile_config_if.sb           cfg
);

  for (genvar t = 0; t < CHAN_W; t++) begin : g_track
    // LUT that this track can pick up
    localparam int LUT_IDX = t % NUM_LUTS;

    always_comb begin
      case (cfg.track_src[t])
        fpga_fabric_pkg::TRACK_PASS: east_chan[t] = west_chan[t];
        fpga_fabric_pkg::TRACK_COMB: east_chan[t] = comb_out[LUT_IDX];
        fpga_fabric_pkg::TRACK_SYNC: east_chan[t] = sync_out[LUT_IDX];
        default:                     east_chan[t] = 1'b0;
      endcase
    end
  end

endmodule

// File: hdl/clb_tile.sv
module clb_tile #(
  parameter int NUM_LUTS = 2,
  parameter int CHAN_W   = 4
) (
  input  logic              clk,
  input  logic              cclk,
  input  logic              reset,
  input  logic              shift_enable,
  input  logic              set_hard,
  input  logic              shift_in,
  output logic              shift_out,
  input  logic [CHAN_W-1:0] west_chan,
  output logic [CHAN_W-1:0] east_chan
);

  //   west_chan --+--> CB --> slice --+
  //               |                   v
  //               +---------------> SB --> east_chan
  //   CFG shadow steers CB, slice and SB

  logic [NUM_LUTS*fpga_fabric_pkg::LUT_K-1:0] lut_in;
  logic [NUM_LUTS-1:0]                        comb_out;
  logic [NUM_LUTS-1:0]                        sync_out;

  tile_config_if #(
    .NUM_LUTS(NUM_LUTS),
    .CHAN_W  (CHAN_W)
  ) cfg_if ();

  config_tile #(
    .NUM_LUTS(NUM_LUTS),
    .CHAN_W  (CHAN_W)
  ) u_config_tile (
    .cclk        (cclk),
    .reset       (reset),
    .shift_enable(shift_enable),
    .set_hard    (set_hard),
    .shift_in    (shift_in),
    .shift_out   (shift_out),
    .cfg         (cfg_if.source)
  );

  connection_block #(
    .NUM_LUTS(NUM_LUTS),
    .CHAN_W  (CHAN_W)
  ) u_connection_block (
    .west_chan(west_chan),
    .lut_in   (lut_in),
    .cfg      (cfg_if.cb)
  );

  slicel #(
    .NUM_LUTS(NUM_LUTS)
  ) u_slicel (
    .clk     (clk),
    .reset   (reset),
    .lut_in  (lut_in),
    .comb_out(comb_out),
    .sync_out(sync_out),
    .cfg     (cfg_if.slice)
  );

  switch_box #(
    .NUM_LUTS(NUM_LUTS),
    .CHAN_W  (CHAN_W)
  ) u_switch_box (
    .west_chan(west_chan),
    .comb_out (comb_out),
    .sync_out (sync_out),
    .east_chan(east_chan),
    .cfg      (cfg_if.sb)
  );

endmodule

// File: hdl/fpga_clb_tiles.sv
module fpga_clb_tiles #(
  parameter int NUM_ROWS = 2,
  parameter int NUM_COLS = 2,
  parameter int NUM_LUTS = 2,
  parameter int CHAN_W   = 4
) (
  input  logic                       clk,    // fabric clock
  input  logic                       cclk,   // configuration clock
  input  logic                       reset,

  // Configuration runs per column, bottom row first
  input  logic [NUM_COLS-1:0]        shift_enable,
  input  logic [NUM_COLS-1:0]        set_hard,
  input  logic [NUM_COLS-1:0]        shift_in_hard,
  output logic [NUM_COLS-1:0]        shift_out,

  // One channel per row, west in and east out
  input  logic [NUM_ROWS*CHAN_W-1:0] fabric_in,
  output logic [NUM_ROWS*CHAN_W-1:0] fabric_out
);

  // Channel c of a row is the west side of column c
  wire [CHAN_W-1:0] row_chan [NUM_ROWS][NUM_COLS+1];

  // Link r of a column feeds the tile in row r
  wire chain_link [NUM_ROWS+1][NUM_COLS];

  for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row_io
    assign row_chan[r][0]                  = fabric_in[r*CHAN_W +: CHAN_W];
    assign fabric_out[r*CHAN_W +: CHAN_W]  = row_chan[r][NUM_COLS];
  end

  for (genvar c = 0; c < NUM_COLS; c++) begin : g_col_io
    assign chain_link[0][c] = shift_in_hard[c];
    assign shift_out[c]     = chain_link[NUM_ROWS][c];
  end

  for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
    for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
      clb_tile #(
        .NUM_LUTS(NUM_LUTS),
        .CHAN_W  (CHAN_W)
      ) u_clb_tile (
        .clk         (clk),
        .cclk        (cclk),
        .reset       (reset),
        .shift_enable(shift_enable[c]),
        .set_hard    (set_hard[c]),
        .shift_in    (chain_link[r][c]),
        .shift_out   (chain_link[r+1][c]),
        .west_chan   (row_chan[r][c]),
        .east_chan   (row_chan[r][c+1])
      );
    end
  end

endmodule

// File: testbench/tb_bitstream.svh
`ifndef TB_BITSTREAM_SVH
`define TB_BITSTREAM_SVH

// Configurations held by the testbench, one set per tile
fpga_fabric_pkg::lut_table_t cfg_lut  [NUM_ROWS][NUM_COLS][NUM_LUTS];
logic [SEL_W-1:0]            cfg_sel  [NUM_ROWS][NUM_COLS][NUM_LUTS*LUT_K];
fpga_fabric_pkg::track_src_e cfg_src  [NUM_ROWS][NUM_COLS][CHAN_W];
logic                        cfg_init [NUM_ROWS][NUM_COLS][NUM_LUTS];

int unsigned lcg_state = 83344;

// Upper half of the state, the low bits repeat too quickly
function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state >> 16;
endfunction

function automatic void clear_config();
  cfg_lut  = '{default: '0};
  cfg_sel  = '{default: '0};
  cfg_src  = '{default: fpga_fabric_pkg::TRACK_PASS};
  cfg_init = '{default: 1'b0};
endfunction

function automatic void randomize_config(input bit allow_sync);
  int unsigned pick;
  for (int r = 0; r < NUM_ROWS; r++) begin
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int l = 0; l < NUM_LUTS; l++) begin
        cfg_lut[r][c][l]  = fpga_fabric_pkg::lut_table_t'(lcg_next());
        cfg_init[r][c][l] = 1'(lcg_next());
      end
      for (int i = 0; i < NUM_LUTS*LUT_K; i++) begin
        cfg_sel[r][c][i] = SEL_W'(lcg_next());
      end
      for (int t = 0; t < CHAN_W; t++) begin
        pick = lcg_next() % (allow_sync ? 4 : 3);
        // Without SYNC the third choice becomes OFF
        if (!allow_sync && pick == 2) begin
          pick = 3;
        end
        cfg_src[r][c][t] = fpga_fabric_pkg::track_src_e'(pick);
      end
    end
  end
endfunction

// Tables, then selects, then track sources, then register init values
function automatic logic [CHAIN_N-1:0] pack_tile(input int r, input int c);
  logic [CHAIN_N-1:0] bits;
  int pos;
  bits = '0;
  pos  = 0;
  for (int l = 0; l < NUM_LUTS; l++) begin
    bits[pos +: fpga_fabric_pkg::LUT_SIZE] = cfg_lut[r][c][l];
    pos += fpga_fabric_pkg::LUT_SIZE;
  end
  for (int i = 0; i < NUM_LUTS*LUT_K; i++) begin
    bits[pos +: SEL_W] = cfg_sel[r][c][i];
    pos += SEL_W;
  end
  for (int t = 0; t < CHAN_W; t++) begin
    bits[pos +: SRC_W] = cfg_src[r][c][t];
    pos += SRC_W;
  end
  for (int l = 0; l < NUM_LUTS; l++) begin
    bits[pos] = cfg_init[r][c][l];
    pos++;
  end
  return bits;
endfunction

function automatic fpga_fabric_pkg::track_src_e src_field(input logic [CHAIN_N-1:0] bits,
                                                          input int t);
  return fpga_fabric_pkg::track_src_e'(bits[SRC_LO + t*SRC_W +: SRC_W]);
endfunction

// Top row goes first, so it sits at the low end of the stream
function automatic logic [COL_N-1:0] column_stream(input int c);
  logic [COL_N-1:0] stream;
  for (int r = 0; r < NUM_ROWS; r++) begin
    stream[(NUM_ROWS-1-r)*CHAIN_N +: CHAIN_N] = pack_tile(r, c);
  end
  return stream;
endfunction

// Starts and ends on a falling edge; seen[i] is shift_out after edge i+1
task automatic shift_column(input int c, input logic [COL_N-1:0] stream,
                            output logic [COL_N-1:0] seen);
  int  idx;
  time t_start;
  idx     = 0;
  t_start = $time;
  shift_enable[c] = 1'b1;
  while (idx < COL_N) begin
    if ($time - t_start > (COL_N + 4) * CLK_PERIOD) begin
      abort_run($sformatf("Shifting column %0d stalled after %0d bits", c, idx));
    end
    shift_in_hard[c] = stream[idx];
    @(posedge clk);
    @(negedge clk);
    seen[idx] = shift_out[c];
    idx++;
  end
  shift_enable[c]  = 1'b0;
  shift_in_hard[c] = 1'b0;
endtask

function automatic logic lut_eval(input int r, input int c, input int l,
                                  input logic [CHAN_W-1:0] west);
  logic [LUT_K-1:0] addr;
  for (int k = 0; k < LUT_K; k++) begin
    addr[k] = west[cfg_sel[r][c][l*LUT_K + k]];
  end
  return cfg_lut[r][c][l][addr];
endfunction

// SYNC shows the init value, which holds only right after set_hard
function automatic logic [CHAN_W-1:0] model_row(input int r, input logic [CHAN_W-1:0] west_in);
  logic [CHAN_W-1:0] west;
  logic [CHAN_W-1:0] east;
  west = west_in;
  for (int c = 0; c < NUM_COLS; c++) begin
    for (int t = 0; t < CHAN_W; t++) begin
      case (cfg_src[r][c][t])
        fpga_fabric_pkg::TRACK_PASS: east[t] = west[t];
        fpga_fabric_pkg::TRACK_COMB: east[t] = lut_eval(r, c, t % NUM_LUTS, west);
        fpga_fabric_pkg::TRACK_SYNC: east[t] = cfg_init[r][c][t % NUM_LUTS];
        default:                     east[t] = 1'b0;
      endcase
    end
    west = east;
  end
  return west;
endfunction

`endif

// File: testbench/tb_fpga_clb_tiles.sv
module tb_fpga_clb_tiles;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ROWS    = 2;
  localparam int NUM_COLS    = 2;
  localparam int NUM_LUTS    = 2;
  localparam int CHAN_W      = 4;
  localparam int LUT_K       = fpga_fabric_pkg::LUT_K;
  localparam int SEL_W       = $clog2(CHAN_W);
  localparam int SRC_W       = fpga_fabric_pkg::TRACK_SRC_W;
  localparam int SRC_LO      = NUM_LUTS*fpga_fabric_pkg::LUT_SIZE + NUM_LUTS*LUT_K*SEL_W;
  localparam int CHAIN_N     = SRC_LO + CHAN_W*SRC_W + NUM_LUTS;
  localparam int COL_N       = NUM_ROWS * CHAIN_N;
  localparam int CLK_PERIOD  = 40;
  localparam int WATCHDOG_NS = 2_000_000;

  logic                       clk;
  logic                       cclk;
  logic                       reset;
  logic [NUM_COLS-1:0]        shift_enable;
  logic [NUM_COLS-1:0]        set_hard;
  logic [NUM_COLS-1:0]        shift_in_hard;
  logic [NUM_COLS-1:0]        shift_out;
  logic [NUM_ROWS*CHAN_W-1:0] fabric_in;
  logic [NUM_ROWS*CHAN_W-1:0] fabric_out;

  int err_count;
  int check_count;
  int tests_ok;
  int tests_bad;

  // One table entry: inputs and expected outputs of both rows
  typedef struct packed {
    logic [CHAN_W-1:0] in1;
    logic [CHAN_W-1:0] in0;
    logic [CHAN_W-1:0] exp1;
    logic [CHAN_W-1:0] exp0;
  } row_vec_t;

  row_vec_t reset_tbl[$] = '{16'h0000, 16'hA5A5, 16'h3C3C, 16'hF1F1, 16'h7E7E, 16'hFFFF};

  // Row 0 out is {in[3], in[2], AND, XOR}
  row_vec_t comb_tbl[$] = '{16'h5050, 16'h5151, 16'h5350, 16'h5755,
                            16'h5F5E, 16'h5A58, 16'h5654, 16'h5B59};

  // Row 0 out is {AND, XOR} now over {AND, XOR} of the previous entry
  // The first entry sees the init value 2'b10
  row_vec_t sync_tbl[$] = '{16'h3136, 16'h3F39, 16'h3736, 16'h3031,
                            16'h3834, 16'h3F39, 16'h3332};

  // Row 0 keeps tracks 3 and 1, row 1 drops track 3
  row_vec_t off_tbl[$]  = '{16'hFF7A, 16'h8500, 16'h7A7A, 16'hC642, 16'h3938};

  fpga_clb_tiles #(
    .NUM_ROWS(NUM_ROWS),
    .NUM_COLS(NUM_COLS),
    .NUM_LUTS(NUM_LUTS),
    .CHAN_W  (CHAN_W)
  ) u_fpga_clb_tiles (
    .clk          (clk),
    .cclk         (cclk),
    .reset        (reset),
    .shift_enable (shift_enable),
    .set_hard     (set_hard),
    .shift_in_hard(shift_in_hard),
    .shift_out    (shift_out),
    .fabric_in    (fabric_in),
    .fabric_out   (fabric_out)
  );

  // Both clocks share one period and phase
  always begin
    #(CLK_PERIOD / 2);
    clk  = ~clk;
    cclk = ~cclk;
  end

  task automatic abort_run(input string why);
    $display("%s at %0d ns", why, $time);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic compare_channel(input string what, input logic [CHAN_W-1:0] got,
                                 input logic [CHAN_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_track_src(input string what, input fpga_fabric_pkg::track_src_e got,
                                   input fpga_fabric_pkg::track_src_e exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_shift_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0d ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  `include "tb_bitstream.svh"

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // Shift every column, then load all shadows on one edge
  task automatic configure_all();
    logic [COL_N-1:0] seen;
    for (int c = 0; c < NUM_COLS; c++) begin
      shift_column(c, column_stream(c), seen);
    end
    set_hard = '1;
    @(posedge clk);
    @(negedge clk);
    set_hard = '0;
  endtask

  task automatic apply_table(input string name, input row_vec_t tbl[$]);
    for (int e = 0; e < tbl.size(); e++) begin
      fabric_in = {tbl[e].in1, tbl[e].in0};
      #1;
      compare_channel($sformatf("%s entry %0d row 0", name, e),
                      fabric_out[CHAN_W-1:0], tbl[e].exp0);
      compare_channel($sformatf("%s entry %0d row 1", name, e),
                      fabric_out[2*CHAN_W-1:CHAN_W], tbl[e].exp1);
      @(posedge clk);
      @(negedge clk);
    end
  endtask

  task automatic test_readback();
    logic [COL_N-1:0]   stream;
    logic [COL_N-1:0]   seen;
    logic [COL_N-1:0]   back;
    logic [CHAIN_N-1:0] tile_bits;
    randomize_config(1'b1);
    for (int c = 0; c < NUM_COLS; c++) begin
      stream = column_stream(c);
      shift_column(c, stream, seen);
      back[0] = shift_out[c];
      shift_column(c, '0, seen);
      back[COL_N-1:1] = seen[COL_N-2:0];
      for (int k = 0; k < COL_N; k++) begin
        compare_shift_bit($sformatf("column %0d bit %0d", c, k), back[k], stream[k]);
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
        tile_bits = back[(NUM_ROWS-1-r)*CHAIN_N +: CHAIN_N];
        for (int t = 0; t < CHAN_W; t++) begin
          compare_track_src($sformatf("tile (%0d,%0d) track %0d", r, c, t),
                            src_field(tile_bits, t), cfg_src[r][c][t]);
        end
      end
      // Shadow never loaded, so every row still passes
      fabric_in = {CHAN_W'(lcg_next()), CHAN_W'(lcg_next())};
      #1;
      compare_channel("row 0 after shifting", fabric_out[CHAN_W-1:0], fabric_in[CHAN_W-1:0]);
      compare_channel("row 1 after shifting", fabric_out[2*CHAN_W-1:CHAN_W],
                      fabric_in[2*CHAN_W-1:CHAN_W]);
      @(negedge clk);
    end
    clear_config();
  endtask

  // Tile (0,0) with LUT 0 as 4-input XOR and LUT 1 as 4-input AND
  task automatic setup_xor_and();
    clear_config();
    cfg_lut[0][0][0] = 16'h6996;
    cfg_lut[0][0][1] = 16'h8000;
    for (int i = 0; i < NUM_LUTS*LUT_K; i++) begin
      cfg_sel[0][0][i] = SEL_W'(i % LUT_K);
    end
  endtask

  task automatic test_random_fabrics();
    logic [CHAN_W-1:0] row_in;
    for (int n = 0; n < 20; n++) begin
      randomize_config(1'b0);
      configure_all();
      for (int v = 0; v < 8; v++) begin
        fabric_in = {CHAN_W'(lcg_next()), CHAN_W'(lcg_next())};
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
          row_in = fabric_in[r*CHAN_W +: CHAN_W];
          compare_channel($sformatf("fabric %0d vector %0d row %0d", n, v, r),
                          fabric_out[r*CHAN_W +: CHAN_W], model_row(r, row_in));
        end
        @(negedge clk);
      end
    end
  endtask

  initial begin
    int errs;
    clk           = 1'b0;
    cclk          = 1'b0;
    reset         = 1'b1;
    shift_enable  = '0;
    set_hard      = '0;
    shift_in_hard = '0;
    fabric_in     = '0;
    err_count     = 0;
    check_count   = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    clear_config();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errs = err_count;
    for (int c = 0; c < NUM_COLS; c++) begin
      compare_shift_bit($sformatf("shift_out[%0d] after reset", c), shift_out[c], 1'b0);
    end
    apply_table("reset pass-through", reset_tbl);
    end_test("reset pass-through", errs);

    errs = err_count;
    test_readback();
    end_test("read-back", errs);

    errs = err_count;
    setup_xor_and();
    cfg_src[0][0][0] = fpga_fabric_pkg::TRACK_COMB;
    cfg_src[0][0][1] = fpga_fabric_pkg::TRACK_COMB;
    configure_all();
    apply_table("comb LUTs", comb_tbl);
    end_test("comb LUTs", errs);

    errs = err_count;
    setup_xor_and();
    cfg_src[0][0] = '{fpga_fabric_pkg::TRACK_SYNC, fpga_fabric_pkg::TRACK_SYNC,
                      fpga_fabric_pkg::TRACK_COMB, fpga_fabric_pkg::TRACK_COMB};
    cfg_init[0][0][1] = 1'b1;
    configure_all();
    apply_table("registers", sync_tbl);
    end_test("registers", errs);

    errs = err_count;
    clear_config();
    cfg_src[0][0][0] = fpga_fabric_pkg::TRACK_OFF;
    cfg_src[0][1][2] = fpga_fabric_pkg::TRACK_OFF;
    cfg_src[1][1][3] = fpga_fabric_pkg::TRACK_OFF;
    configure_all();
    apply_table("off and pass", off_tbl);
    end_test("off and pass", errs);

    errs = err_count;
    test_random_fabrics();
    end_test("random fabrics", errs);

    $display("Tests ok: %0d, with errors: %0d, checks: %0d, errors: %0d",
             tests_ok, tests_bad, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Run exceeded its time limit");
  end

endmodule

// File: src.f
+incdir+testbench
hdl/fpga_fabric_pkg.sv
hdl/tile_config_if.sv
hdl/config_tile.sv
hdl/slicel.sv
hdl/connection_block.sv
hdl/switch_box.sv
hdl/clb_tile.sv
hdl/fpga_clb_tiles.sv
testbench/tb_fpga_clb_tiles.sv

// File: Bender.yml
package:
  name: fpga_clb_tiles

sources:
  - files:
      - hdl/fpga_fabric_pkg.sv
      - hdl/tile_config_if.sv
      - hdl/config_tile.sv
      - hdl/slicel.sv
      - hdl/connection_block.sv
      - hdl/switch_box.sv
      - hdl/clb_tile.sv
      - hdl/fpga_clb_tiles.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_fpga_clb_tiles.sv
